/* tiny_pipe_macros.svh */
`ifndef TINY_PIPE_MACROS_SVH
`define TINY_PIPE_MACROS_SVH

// widths
`define TP_WORD_W      32
`define TP_REG_ADDR_W  5
`define TP_NUM_REGS    32
`define TP_ALU_OP_W    4

// instruction fields
`define TP_RD_F        4:0
`define TP_RJ_F        9:5
`define TP_RK_F        14:10
`define TP_SI12_F      21:10
`define TP_SI20_F      24:5
`define TP_OP17_F      31:15
`define TP_OP10_F      31:22
`define TP_OP7_F       31:25

// major opcodes, register-register group (bits 31:15)
`define TP_OP_ADD_W    17'h00020
`define TP_OP_SUB_W    17'h00022
`define TP_OP_SLT      17'h00024
`define TP_OP_SLTU     17'h00025
`define TP_OP_AND      17'h00029
`define TP_OP_OR       17'h0002a
`define TP_OP_XOR      17'h0002b

// 12-bit immediate group (bits 31:22)
`define TP_OP_ADDI_W   10'h00a
`define TP_OP_ANDI     10'h00d
`define TP_OP_ORI      10'h00e

`define TP_OP_LU12I_W  7'h0a   // bits 31:25

// alu operation codes
`define TP_ALU_ADD     4'd0
`define TP_ALU_SUB     4'd1
`define TP_ALU_AND     4'd2
`define TP_ALU_OR      4'd3
`define TP_ALU_XOR     4'd4
`define TP_ALU_SLT     4'd5
`define TP_ALU_SLTU    4'd6
`define TP_ALU_LUI     4'd7

`endif

/* tiny_pipe_pkg.sv */
`default_nettype none

`include "tiny_pipe_macros.svh"

package tiny_pipe_pkg;

    // data word, also the width of every operand and result
    typedef logic [`TP_WORD_W-1:0] word_t;

    // raw instruction word as it arrives on the input port
    typedef logic [`TP_WORD_W-1:0] inst_t;

    typedef logic [`TP_REG_ADDR_W-1:0] reg_addr_t;  // register index

    typedef logic [`TP_ALU_OP_W-1:0] alu_op_t;  // see TP_ALU_* codes

endpackage

`default_nettype wire

/* reg_file.sv */
`default_nettype none
`timescale 1ns/10ps

`include "tiny_pipe_macros.svh"

module reg_file (
    input  wire                       clk_i,
    input  wire                       locked_i,
    input  tiny_pipe_pkg::reg_addr_t  raddr_a_i,
    input  tiny_pipe_pkg::reg_addr_t  raddr_b_i,
    input  tiny_pipe_pkg::reg_addr_t  waddr_i,
    input  wire                       we_i,
    input  tiny_pipe_pkg::word_t      wdata_i,
    output tiny_pipe_pkg::word_t      rdata_a_o,
    output tiny_pipe_pkg::word_t      rdata_b_o
);
    import tiny_pipe_pkg::*;

    word_t regs [1:`TP_NUM_REGS-1];  // r0 has no storage

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            for (int i = 1; i < `TP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // asynchronous reads
    // no write bypass, the result slot forward covers that cycle
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none
`timescale 1ns/10ps

`include "tiny_pipe_macros.svh"

module decode_stage (
    input  wire                       clk_i,
    input  wire                       locked_i,
    // instruction port
    input  wire                       inst_valid_i,
    input  tiny_pipe_pkg::inst_t      inst_i,
    output logic                      inst_ready_o,
    input  wire                       ex_allow_in_i,
    // forwarding from execute and result slots
    input  wire                       ex_fwd_valid_i,
    input  wire                       ex_fwd_we_i,
    input  tiny_pipe_pkg::reg_addr_t  ex_fwd_dest_i,
    input  tiny_pipe_pkg::word_t      ex_fwd_data_i,
    input  wire                       res_fwd_valid_i,
    input  wire                       res_fwd_we_i,
    input  tiny_pipe_pkg::reg_addr_t  res_fwd_dest_i,
    input  tiny_pipe_pkg::word_t      res_fwd_data_i,
    // register file read
    output tiny_pipe_pkg::reg_addr_t  rf_raddr_a_o,
    output tiny_pipe_pkg::reg_addr_t  rf_raddr_b_o,
    input  tiny_pipe_pkg::word_t      rf_rdata_a_i,
    input  tiny_pipe_pkg::word_t      rf_rdata_b_i,
    // to execute
    output logic                      id_valid_o,
    output tiny_pipe_pkg::alu_op_t    id_alu_op_o,
    output tiny_pipe_pkg::word_t      id_opnd_a_o,
    output tiny_pipe_pkg::word_t      id_opnd_b_o,
    output tiny_pipe_pkg::reg_addr_t  id_dest_o,
    output logic                      id_we_o
);
    import tiny_pipe_pkg::*;

    logic       id_valid_q;
    inst_t      inst_q;
    alu_op_t    dec_op;
    word_t      dec_imm;
    logic       dec_use_imm;
    logic       dec_legal;  // known encoding, writes rd
    word_t      src_a;
    word_t      src_b;
    logic [11:0] si12;

    // slot empty, or it moves on this edge
    assign inst_ready_o = ~id_valid_q | ex_allow_in_i;

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            id_valid_q <= 1'b0;
        end else if (inst_ready_o) begin
            id_valid_q <= inst_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_valid_i && inst_ready_o) begin
            inst_q <= inst_i;
        end
    end

    // operand source: execute slot, then result slot, then register file
    function automatic word_t fwd_pick(reg_addr_t addr, word_t rf_data);
        word_t pick;
        pick = rf_data;
        if (res_fwd_valid_i && res_fwd_we_i && (res_fwd_dest_i != '0) &&
            (res_fwd_dest_i == addr)) begin
            pick = res_fwd_data_i;
        end
        if (ex_fwd_valid_i && ex_fwd_we_i && (ex_fwd_dest_i != '0) &&
            (ex_fwd_dest_i == addr)) begin
            pick = ex_fwd_data_i;
        end
        return pick;
    endfunction

    assign rf_raddr_a_o = inst_q[`TP_RJ_F];
    assign rf_raddr_b_o = inst_q[`TP_RK_F];
    assign si12         = inst_q[`TP_SI12_F];

    always_comb begin
        src_a = fwd_pick(rf_raddr_a_o, rf_rdata_a_i);
        src_b = fwd_pick(rf_raddr_b_o, rf_rdata_b_i);
    end

    always_comb begin
        dec_op      = `TP_ALU_ADD;
        dec_imm     = '0;
        dec_use_imm = 1'b0;
        dec_legal   = 1'b1;
        if (inst_q[`TP_OP7_F] == `TP_OP_LU12I_W) begin
            dec_op      = `TP_ALU_LUI;
            dec_imm     = {12'b0, inst_q[`TP_SI20_F]};  // shifted up in the alu
            dec_use_imm = 1'b1;
        end else if (inst_q[`TP_OP10_F] == `TP_OP_ADDI_W) begin
            dec_imm     = {{(`TP_WORD_W-12){si12[11]}}, si12};
            dec_use_imm = 1'b1;
        end else if (inst_q[`TP_OP10_F] == `TP_OP_ANDI) begin
            dec_op      = `TP_ALU_AND;
            dec_imm     = {{(`TP_WORD_W-12){1'b0}}, si12};
            dec_use_imm = 1'b1;
        end else if (inst_q[`TP_OP10_F] == `TP_OP_ORI) begin
            dec_op      = `TP_ALU_OR;
            dec_imm     = {{(`TP_WORD_W-12){1'b0}}, si12};
            dec_use_imm = 1'b1;
        end else begin
            case (inst_q[`TP_OP17_F])
                `TP_OP_ADD_W: dec_op = `TP_ALU_ADD;
                `TP_OP_SUB_W: dec_op = `TP_ALU_SUB;
                `TP_OP_AND:   dec_op = `TP_ALU_AND;
                `TP_OP_OR:    dec_op = `TP_ALU_OR;
                `TP_OP_XOR:   dec_op = `TP_ALU_XOR;
                `TP_OP_SLT:   dec_op = `TP_ALU_SLT;
                `TP_OP_SLTU:  dec_op = `TP_ALU_SLTU;
                default:      dec_legal = 1'b0;
            endcase
        end
    end

    // unknown encodings become add 0 + 0 with no write
    assign id_valid_o  = id_valid_q;
    assign id_alu_op_o = dec_op;
    assign id_opnd_a_o = dec_legal ? src_a : '0;
    assign id_opnd_b_o = !dec_legal ? '0 : (dec_use_imm ? dec_imm : src_b);
    assign id_dest_o   = dec_legal ? inst_q[`TP_RD_F] : '0;
    assign id_we_o     = dec_legal;

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none
`timescale 1ns/10ps

`include "tiny_pipe_macros.svh"

module execute_stage (
    input  wire                       clk_i,
    input  wire                       locked_i,
    // from decode
    input  wire                       id_valid_i,
    input  tiny_pipe_pkg::alu_op_t    id_alu_op_i,
    input  tiny_pipe_pkg::word_t      id_opnd_a_i,
    input  tiny_pipe_pkg::word_t      id_opnd_b_i,
    input  tiny_pipe_pkg::reg_addr_t  id_dest_i,
    input  wire                       id_we_i,
    output logic                      ex_allow_in_o,
    // forward back to decode
    output logic                      ex_fwd_valid_o,
    output logic                      ex_fwd_we_o,
    output tiny_pipe_pkg::reg_addr_t  ex_fwd_dest_o,
    output tiny_pipe_pkg::word_t      ex_fwd_data_o,
    // to result
    input  wire                       res_allow_in_i,
    output logic                      ex_valid_o,
    output tiny_pipe_pkg::reg_addr_t  ex_dest_o,
    output logic                      ex_we_o,
    output tiny_pipe_pkg::word_t      ex_result_o
);
    import tiny_pipe_pkg::*;

    logic       ex_valid_q;
    alu_op_t    op_q;
    word_t      a_q;
    word_t      b_q;
    reg_addr_t  dest_q;
    logic       we_q;
    word_t      alu_res;

    assign ex_allow_in_o = ~ex_valid_q | res_allow_in_i;

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            ex_valid_q <= 1'b0;
        end else if (ex_allow_in_o) begin
            ex_valid_q <= id_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (id_valid_i && ex_allow_in_o) begin
            op_q   <= id_alu_op_i;
            a_q    <= id_opnd_a_i;
            b_q    <= id_opnd_b_i;
            dest_q <= id_dest_i;
            we_q   <= id_we_i;
        end
    end

    // combinational so it can be forwarded in the same cycle
    always_comb begin
        case (op_q)
            `TP_ALU_ADD:  alu_res = a_q + b_q;  // wraps
            `TP_ALU_SUB:  alu_res = a_q - b_q;
            `TP_ALU_AND:  alu_res = a_q & b_q;
            `TP_ALU_OR:   alu_res = a_q | b_q;
            `TP_ALU_XOR:  alu_res = a_q ^ b_q;
            `TP_ALU_SLT:  alu_res = {{(`TP_WORD_W-1){1'b0}}, $signed(a_q) < $signed(b_q)};
            `TP_ALU_SLTU: alu_res = {{(`TP_WORD_W-1){1'b0}}, a_q < b_q};
            `TP_ALU_LUI:  alu_res = {b_q[19:0], 12'h000};
            default:      alu_res = '0;
        endcase
    end

    assign ex_valid_o  = ex_valid_q;
    assign ex_dest_o   = dest_q;
    assign ex_we_o     = we_q;
    assign ex_result_o = alu_res;

    assign ex_fwd_valid_o = ex_valid_q;
    assign ex_fwd_we_o    = we_q;
    assign ex_fwd_dest_o  = dest_q;
    assign ex_fwd_data_o  = alu_res;

endmodule

`default_nettype wire

/* result_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module result_stage (
    input  wire                       clk_i,
    input  wire                       locked_i,
    // from execute
    input  wire                       ex_valid_i,
    input  tiny_pipe_pkg::reg_addr_t  ex_dest_i,
    input  wire                       ex_we_i,
    input  tiny_pipe_pkg::word_t      ex_result_i,
    output logic                      res_allow_in_o,
    // forward back to decode
    output logic                      res_fwd_valid_o,
    output logic                      res_fwd_we_o,
    output tiny_pipe_pkg::reg_addr_t  res_fwd_dest_o,
    output tiny_pipe_pkg::word_t      res_fwd_data_o,
    // retire port
    output logic                      retire_valid_o,
    output logic                      retire_we_o,
    output tiny_pipe_pkg::reg_addr_t  retire_dest_o,
    output tiny_pipe_pkg::word_t      retire_data_o,
    input  wire                       retire_ready_i,
    // register file write
    output logic                      rf_we_o,
    output tiny_pipe_pkg::reg_addr_t  rf_waddr_o,
    output tiny_pipe_pkg::word_t      rf_wdata_o
);
    import tiny_pipe_pkg::*;

    logic       res_valid_q;
    reg_addr_t  dest_q;
    logic       we_q;
    word_t      data_q;

    // retire_ready_i empties the slot on this edge
    assign res_allow_in_o = ~res_valid_q | retire_ready_i;

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            res_valid_q <= 1'b0;
        end else if (res_allow_in_o) begin
            res_valid_q <= ex_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_valid_i && res_allow_in_o) begin
            dest_q <= ex_dest_i;
            we_q   <= ex_we_i;
            data_q <= ex_result_i;
        end
    end

    assign retire_valid_o = res_valid_q;
    assign retire_we_o    = we_q;
    assign retire_dest_o  = dest_q;
    assign retire_data_o  = data_q;

    assign rf_we_o    = res_valid_q & retire_ready_i & we_q;  // only on the retiring edge
    assign rf_waddr_o = dest_q;
    assign rf_wdata_o = data_q;

    assign res_fwd_valid_o = res_valid_q;
    assign res_fwd_we_o    = we_q;
    assign res_fwd_dest_o  = dest_q;
    assign res_fwd_data_o  = data_q;

endmodule

`default_nettype wire

/* tiny_pipe_top.sv */
`default_nettype none
`timescale 1ns/10ps

module tiny_pipe_top (
    input  wire                       clk_i,
    input  wire                       locked_i,
    input  wire                       inst_valid_i,
    input  tiny_pipe_pkg::inst_t      inst_i,
    output logic                      inst_ready_o,
    output logic                      retire_valid_o,
    output logic                      retire_we_o,
    output tiny_pipe_pkg::reg_addr_t  retire_dest_o,
    output tiny_pipe_pkg::word_t      retire_data_o,
    input  wire                       retire_ready_i
);
    import tiny_pipe_pkg::*;

    // decode to execute
    logic       id_valid, id_we;
    alu_op_t    id_alu_op;
    word_t      id_opnd_a, id_opnd_b;
    reg_addr_t  id_dest;
    // execute to result
    logic       ex_valid, ex_we;
    reg_addr_t  ex_dest;
    word_t      ex_result;
    // allow-in chain
    logic       ex_allow_in, res_allow_in;
    // forwarding
    logic       ex_fwd_valid, ex_fwd_we, res_fwd_valid, res_fwd_we;
    reg_addr_t  ex_fwd_dest, res_fwd_dest;
    word_t      ex_fwd_data, res_fwd_data;
    // register file
    reg_addr_t  rf_raddr_a, rf_raddr_b, rf_waddr;
    word_t      rf_rdata_a, rf_rdata_b, rf_wdata;
    logic       rf_we;

    decode_stage u_decode (
        .clk_i, .locked_i, .inst_valid_i, .inst_i, .inst_ready_o,
        .ex_allow_in_i(ex_allow_in),
        .ex_fwd_valid_i(ex_fwd_valid), .ex_fwd_we_i(ex_fwd_we),
        .ex_fwd_dest_i(ex_fwd_dest), .ex_fwd_data_i(ex_fwd_data),
        .res_fwd_valid_i(res_fwd_valid), .res_fwd_we_i(res_fwd_we),
        .res_fwd_dest_i(res_fwd_dest), .res_fwd_data_i(res_fwd_data),
        .rf_raddr_a_o(rf_raddr_a), .rf_raddr_b_o(rf_raddr_b),
        .rf_rdata_a_i(rf_rdata_a), .rf_rdata_b_i(rf_rdata_b),
        .id_valid_o(id_valid), .id_alu_op_o(id_alu_op), .id_opnd_a_o(id_opnd_a),
        .id_opnd_b_o(id_opnd_b), .id_dest_o(id_dest), .id_we_o(id_we)
    );

    execute_stage u_execute (
        .clk_i, .locked_i,
        .id_valid_i(id_valid), .id_alu_op_i(id_alu_op), .id_opnd_a_i(id_opnd_a),
        .id_opnd_b_i(id_opnd_b), .id_dest_i(id_dest), .id_we_i(id_we),
        .ex_allow_in_o(ex_allow_in),
        .ex_fwd_valid_o(ex_fwd_valid), .ex_fwd_we_o(ex_fwd_we),
        .ex_fwd_dest_o(ex_fwd_dest), .ex_fwd_data_o(ex_fwd_data),
        .res_allow_in_i(res_allow_in),
        .ex_valid_o(ex_valid), .ex_dest_o(ex_dest), .ex_we_o(ex_we),
        .ex_result_o(ex_result)
    );

    result_stage u_result (
        .clk_i, .locked_i,
        .ex_valid_i(ex_valid), .ex_dest_i(ex_dest), .ex_we_i(ex_we),
        .ex_result_i(ex_result), .res_allow_in_o(res_allow_in),
        .res_fwd_valid_o(res_fwd_valid), .res_fwd_we_o(res_fwd_we),
        .res_fwd_dest_o(res_fwd_dest), .res_fwd_data_o(res_fwd_data),
        .retire_valid_o, .retire_we_o, .retire_dest_o, .retire_data_o, .retire_ready_i,
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata)
    );

    reg_file u_reg_file (
        .clk_i, .locked_i,
        .raddr_a_i(rf_raddr_a), .raddr_b_i(rf_raddr_b),
        .waddr_i(rf_waddr), .we_i(rf_we), .wdata_i(rf_wdata),
        .rdata_a_o(rf_rdata_a), .rdata_b_o(rf_rdata_b)
    );

endmodule

`default_nettype wire

/* tiny_pipe_tb.sv */
`default_nettype none
`timescale 1ns/10ps

`include "tiny_pipe_macros.svh"

module tiny_pipe_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_ROWS        = 25;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * NUM_ROWS;

    logic        clk_i;
    logic        locked_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        inst_ready_o;
    logic        retire_valid_o;
    logic        retire_we_o;
    logic [4:0]  retire_dest_o;
    logic [31:0] retire_data_o;
    logic        retire_ready_i;

    // expected retire stream with one row per instruction
    logic [31:0] tbl_inst [NUM_ROWS];
    logic        tbl_we   [NUM_ROWS];
    logic [4:0]  tbl_dest [NUM_ROWS];
    logic [31:0] tbl_data [NUM_ROWS];
    int          n_rows    = 0;

    int          sent      = 0;  // instructions accepted by the DUT
    int          retired   = 0;
    logic [31:0] rng_state;

    tiny_pipe_top dut_i (
        .clk_i          (clk_i),
        .locked_i       (locked_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_ready_o   (inst_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_we_o    (retire_we_o),
        .retire_dest_o  (retire_dest_o),
        .retire_data_o  (retire_data_o),
        .retire_ready_i (retire_ready_i)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction encoders following the LoongArch32 field layout
    function automatic logic [31:0] enc_rr(input logic [16:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [9:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] imm);
        return {`TP_OP_LU12I_W, imm, rd};
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            fail_stop($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                                $time, name, got, exp));
    endtask

    task automatic add_row(input logic [31:0] inst, input logic we, input logic [4:0] dest,
                           input logic [31:0] data);
        tbl_inst[n_rows] = inst;
        tbl_we[n_rows]   = we;
        tbl_dest[n_rows] = dest;
        tbl_data[n_rows] = data;
        n_rows++;
    endtask

    // expected values worked out by hand from the instruction rules
    task automatic build_table();
        add_row(enc_lu12i(5'd1, 20'h12345), 1'b1, 5'd1, 32'h1234_5000);
        add_row(enc_i12(`TP_OP_ORI, 5'd1, 5'd1, 12'h678), 1'b1, 5'd1, 32'h1234_5678);  // dist 1
        add_row(enc_lu12i(5'd2, 20'h80000), 1'b1, 5'd2, 32'h8000_0000);
        add_row(enc_i12(`TP_OP_ORI, 5'd3, 5'd0, 12'h001), 1'b1, 5'd3, 32'h0000_0001);
        add_row(enc_rr(`TP_OP_ADD_W, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, 32'h9234_5678);  // dist 3, 2
        add_row(enc_rr(`TP_OP_SUB_W, 5'd5, 5'd3, 5'd2), 1'b1, 5'd5, 32'h8000_0001);
        add_row(enc_rr(`TP_OP_SLT, 5'd6, 5'd2, 5'd3), 1'b1, 5'd6, 32'h0000_0001);   // signed
        add_row(enc_rr(`TP_OP_SLTU, 5'd7, 5'd2, 5'd3), 1'b1, 5'd7, 32'h0000_0000);  // unsigned
        add_row(enc_lu12i(5'd8, 20'hfffff), 1'b1, 5'd8, 32'hffff_f000);
        add_row(enc_i12(`TP_OP_ORI, 5'd8, 5'd8, 12'hfff), 1'b1, 5'd8, 32'hffff_ffff);
        add_row(enc_rr(`TP_OP_ADD_W, 5'd9, 5'd8, 5'd3), 1'b1, 5'd9, 32'h0000_0000);  // wraps
        add_row(enc_rr(`TP_OP_SUB_W, 5'd10, 5'd0, 5'd3), 1'b1, 5'd10, 32'hffff_ffff);
        add_row(enc_rr(`TP_OP_AND, 5'd11, 5'd4, 5'd5), 1'b1, 5'd11, 32'h8000_0000);
        add_row(enc_rr(`TP_OP_OR, 5'd12, 5'd11, 5'd3), 1'b1, 5'd12, 32'h8000_0001);
        add_row(enc_rr(`TP_OP_XOR, 5'd13, 5'd12, 5'd1), 1'b1, 5'd13, 32'h9234_5679);
        // a write to r0 still retires and the next read must see zero
        add_row(enc_i12(`TP_OP_ADDI_W, 5'd0, 5'd1, 12'h123), 1'b1, 5'd0, 32'h1234_579b);
        add_row(enc_rr(`TP_OP_ADD_W, 5'd14, 5'd0, 5'd3), 1'b1, 5'd14, 32'h0000_0001);
        add_row(32'hffff_ffff, 1'b0, 5'd0, 32'h0000_0000);  // unknown encoding
        add_row(enc_i12(`TP_OP_ADDI_W, 5'd15, 5'd14, 12'hfff), 1'b1, 5'd15, 32'h0000_0000);
        add_row(enc_rr(`TP_OP_SLTU, 5'd16, 5'd3, 5'd10), 1'b1, 5'd16, 32'h0000_0001);
        add_row(enc_rr(`TP_OP_SLT, 5'd17, 5'd10, 5'd3), 1'b1, 5'd17, 32'h0000_0001);
        add_row(enc_i12(`TP_OP_ANDI, 5'd18, 5'd8, 12'h0f0), 1'b1, 5'd18, 32'h0000_00f0);
        add_row(enc_rr(`TP_OP_XOR, 5'd19, 5'd18, 5'd13), 1'b1, 5'd19, 32'h9234_5689);
        add_row(enc_i12(`TP_OP_ADDI_W, 5'd20, 5'd19, 12'h800), 1'b1, 5'd20, 32'h9234_4e89);
        add_row(enc_i12(`TP_OP_ORI, 5'd21, 5'd0, 12'h800), 1'b1, 5'd21, 32'h0000_0800);
    endtask

    task automatic check_retire(input int idx);
        assert (idx < NUM_ROWS) else
            fail_stop($sformatf("extra retirement after all %0d rows at %0t ns",
                                NUM_ROWS, $time));
        check_field("retire_we_o", {31'b0, retire_we_o}, {31'b0, tbl_we[idx]});
        check_field("retire_dest_o", {27'b0, retire_dest_o}, {27'b0, tbl_dest[idx]});
        check_field("retire_data_o", retire_data_o, tbl_data[idx]);
    endtask

    // retire side sampled mid-cycle where the handshake is stable
    initial begin : retire_check
        forever begin
            @(negedge clk_i);
            if (retire_valid_o && retire_ready_i) begin
                check_retire(retired);
                retired++;
            end
        end
    end

    initial begin : stimulus
        logic        taken;
        logic [31:0] rnd;
        locked_i       <= 1'b0;
        inst_valid_i   <= 1'b0;
        inst_i         <= '0;
        retire_ready_i <= 1'b0;
        rng_state = 32'd91899;
        build_table();

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        check_field("inst_ready_o", {31'b0, inst_ready_o}, 32'd1);  // still in reset
        check_field("retire_valid_o", {31'b0, retire_valid_o}, 32'd0);
        @(posedge clk_i);
        locked_i <= 1'b1;
        @(negedge clk_i);
        check_field("inst_ready_o", {31'b0, inst_ready_o}, 32'd1);
        check_field("retire_valid_o", {31'b0, retire_valid_o}, 32'd0);
        @(posedge clk_i);

        while (retired < NUM_ROWS) begin
            @(negedge clk_i);
            taken = inst_valid_i && inst_ready_o;  // handshake on the coming edge
            if (taken) begin
                sent++;
            end
            @(posedge clk_i);
            rnd       = xorshift32(rng_state);
            rng_state = rnd;
            // an offer stays up until it is taken
            if (!inst_valid_i || taken) begin
                if ((sent < NUM_ROWS) && (rnd[1:0] != 2'd0)) begin
                    inst_valid_i <= 1'b1;
                    inst_i       <= tbl_inst[sent];
                end else begin
                    inst_valid_i <= 1'b0;
                end
            end
            retire_ready_i <= (rnd[6:4] < 3'd5);  // back-pressure about 3 cycles in 8
        end

        // nothing more may come out while the pipe drains
        inst_valid_i   <= 1'b0;
        retire_ready_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        check_field("retire_valid_o", {31'b0, retire_valid_o}, 32'd0);
        check_field("inst_ready_o", {31'b0, inst_ready_o}, 32'd1);

        if ((sent == NUM_ROWS) && (retired == NUM_ROWS)) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_stop($sformatf("run ended with %0d sent and %0d retired of %0d rows",
                                sent, retired, NUM_ROWS));
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_stop($sformatf("timeout: retirements stopped at %0d of %0d rows",
                            retired, NUM_ROWS));
    end

endmodule

`default_nettype wire

/* tiny_pipe.f */
+incdir+.
tiny_pipe_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
tiny_pipe_top.sv
tiny_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tiny_pipe_tb -f tiny_pipe.f -Mdir obj_dir -o tiny_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tiny_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
